/* common/uart_rx_pkg.sv */
package uart_rx_pkg;

    // widths with a meaning of their own
    typedef logic [2:0]  apb_addr_t;
    typedef logic [7:0]  data_t;
    typedef logic [13:0] bit_period_t;
    typedef logic [3:0]  data_size_t;
    typedef logic [3:0]  bit_index_t;

    // register map
    localparam apb_addr_t ADDR_STATUS        = 3'd0;
    localparam apb_addr_t ADDR_ERROR         = 3'd1;
    localparam apb_addr_t ADDR_BIT_PERIOD_LO = 3'd2;
    localparam apb_addr_t ADDR_BIT_PERIOD_HI = 3'd3;
    localparam apb_addr_t ADDR_DATA_SIZE     = 3'd4;
    localparam apb_addr_t ADDR_RX_DATA       = 3'd6;

    // values after reset
    localparam bit_period_t BIT_PERIOD_RESET = 14'd10;
    localparam data_size_t  DATA_SIZE_RESET  = 4'd8;

    // error register codes, framing reported first
    localparam data_t ERROR_CODE_FRAMING = 8'd1;
    localparam data_t ERROR_CODE_OVERRUN = 8'd2;

    // register block to receiver
    typedef struct packed {
        bit_period_t bit_period;
        data_size_t  data_size;
    } rx_config_t;

    // control machine to buffer, load is a one cycle strobe
    typedef struct packed {
        logic  load;
        data_t data;
        logic  framing_error;
    } rx_frame_t;

    // buffer back to register block
    typedef struct packed {
        data_t rx_data;
        logic  data_ready;
        logic  overrun_error;
        logic  framing_error;
    } rx_status_t;

    // receive FSM
    typedef enum logic [2:0] {
        idle,
        start_check,
        receive,
        stop_check,
        load_frame
    } rx_state_t;

endpackage

/* apb_slave/apb_slave.sv */
`timescale 1ns/1ns

module apb_slave (
    input  logic                    clk,
    input  logic                    n_rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  uart_rx_pkg::apb_addr_t  paddr,
    input  uart_rx_pkg::data_t      pwdata,
    input  uart_rx_pkg::rx_status_t status,
    output uart_rx_pkg::data_t      prdata,
    output logic                    pslverr,
    output logic                    data_read,
    output uart_rx_pkg::rx_config_t config_out
);

    uart_rx_pkg::bit_period_t bit_period;
    uart_rx_pkg::bit_period_t next_bit_period;
    uart_rx_pkg::data_size_t  data_size;
    uart_rx_pkg::data_size_t  next_data_size;
    uart_rx_pkg::data_t       next_prdata;
    uart_rx_pkg::data_t       error_code;
    logic                     next_pslverr;
    logic                     next_data_read;
    logic                     setup;

    // decode only in the setup phase so each transfer acts once
    assign setup = psel && !penable;

    // framing outranks overrun
    always_comb begin
        if (status.framing_error) begin
            error_code = uart_rx_pkg::ERROR_CODE_FRAMING;
        end else if (status.overrun_error) begin
            error_code = uart_rx_pkg::ERROR_CODE_OVERRUN;
        end else begin
            error_code = '0;
        end
    end

    // configuration registers
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            bit_period <= uart_rx_pkg::BIT_PERIOD_RESET;
            data_size  <= uart_rx_pkg::DATA_SIZE_RESET;
        end else begin
            bit_period <= next_bit_period;
            data_size  <= next_data_size;
        end
    end

    // bus side outputs, all valid in the access cycle
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            prdata    <= '0;
            pslverr   <= 1'b0;
            data_read <= 1'b0;
        end else begin
            prdata    <= next_prdata;
            pslverr   <= next_pslverr;
            data_read <= next_data_read;
        end
    end

    always_comb begin
        next_bit_period = bit_period;
        next_data_size  = data_size;
        next_prdata     = prdata;
        next_pslverr    = 1'b0;
        next_data_read  = 1'b0;
        if (setup) begin
            case (paddr)
                uart_rx_pkg::ADDR_STATUS: begin
                    // read only
                    if (pwrite) begin
                        next_pslverr = 1'b1;
                    end else begin
                        next_prdata = {7'd0, status.data_ready};
                    end
                end
                uart_rx_pkg::ADDR_ERROR: begin
                    if (pwrite) begin
                        next_pslverr = 1'b1;
                    end else begin
                        next_prdata = error_code;
                    end
                end
                uart_rx_pkg::ADDR_BIT_PERIOD_LO: begin
                    if (pwrite) begin
                        next_bit_period[7:0] = pwdata;
                    end else begin
                        next_prdata = bit_period[7:0];
                    end
                end
                uart_rx_pkg::ADDR_BIT_PERIOD_HI: begin
                    // only 6 bits exist up here
                    if (pwrite) begin
                        next_bit_period[13:8] = pwdata[5:0];
                    end else begin
                        next_prdata = {2'b00, bit_period[13:8]};
                    end
                end
                uart_rx_pkg::ADDR_DATA_SIZE: begin
                    if (pwrite) begin
                        next_data_size = pwdata[3:0];
                    end else begin
                        next_prdata = {4'd0, data_size};
                    end
                end
                uart_rx_pkg::ADDR_RX_DATA: begin
                    // buffer clears its flags on the data_read pulse
                    if (pwrite) begin
                        next_pslverr = 1'b1;
                    end else begin
                        next_prdata    = status.rx_data;
                        next_data_read = 1'b1;
                    end
                end
                default: begin
                    // addresses 5 and 7 are silently ignored
                end
            endcase
        end
    end

    assign config_out.bit_period = bit_period;
    assign config_out.data_size  = data_size;

endmodule

/* uart_receiver/rx_timer.sv */
`timescale 1ns/1ns

module rx_timer (
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      enable,
    input  uart_rx_pkg::bit_period_t  bit_period,
    output logic                      sample,
    output uart_rx_pkg::bit_index_t   bit_index
);

    uart_rx_pkg::bit_period_t period;
    uart_rx_pkg::bit_period_t count;

    // strobe when the count runs out, covers tiny periods too
    assign sample = enable && (count <= 14'd1);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            period    <= uart_rx_pkg::BIT_PERIOD_RESET;
            count     <= '0;
            bit_index <= '0;
        end else if (!enable) begin
            // between frames, pick up the period and arm for half a bit
            period    <= bit_period;
            count     <= bit_period >> 1;
            bit_index <= '0;
        end else if (sample) begin
            // full bit to the next mid point
            count     <= period;
            bit_index <= bit_index + 4'd1;
        end else begin
            count <= count - 14'd1;
        end
    end

endmodule

/* uart_receiver/rx_control.sv */
`timescale 1ns/1ns

module rx_control (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     serial_in,
    input  uart_rx_pkg::data_size_t  data_size,
    input  logic                     sample,
    input  uart_rx_pkg::bit_index_t  bit_index,
    output logic                     timer_enable,
    output logic                     sample_bit,
    output logic                     sample_write,
    output uart_rx_pkg::rx_frame_t   frame
);

    uart_rx_pkg::rx_state_t  state;
    uart_rx_pkg::rx_state_t  next_state;
    uart_rx_pkg::data_size_t size_q;
    logic                    sync_1;
    logic                    sync_2;
    logic                    line_prev;
    logic                    stop_low;
    logic                    falling;
    logic                    last_bit;

    // two flop synchronizer plus one more for edge detect
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            sync_1    <= 1'b1;
            sync_2    <= 1'b1;
            line_prev <= 1'b1;
        end else begin
            sync_1    <= serial_in;
            sync_2    <= sync_1;
            line_prev <= sync_2;
        end
    end

    assign falling  = line_prev && !sync_2;
    // clamp so a bad size still ends the frame
    assign last_bit = (bit_index >= size_q) || (bit_index == 4'd8);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= uart_rx_pkg::idle;
            size_q   <= uart_rx_pkg::DATA_SIZE_RESET;
            stop_low <= 1'b0;
        end else begin
            state <= next_state;
            // size is frozen for the whole frame
            if (state == uart_rx_pkg::idle) begin
                size_q <= data_size;
            end
            if (state == uart_rx_pkg::stop_check && sample) begin
                stop_low <= !sync_2;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            uart_rx_pkg::idle: begin
                if (falling) begin
                    next_state = uart_rx_pkg::start_check;
                end
            end
            uart_rx_pkg::start_check: begin
                // line back high mid start bit means a glitch
                if (sample) begin
                    next_state = sync_2 ? uart_rx_pkg::idle : uart_rx_pkg::receive;
                end
            end
            uart_rx_pkg::receive: begin
                if (sample && last_bit) begin
                    next_state = uart_rx_pkg::stop_check;
                end
            end
            uart_rx_pkg::stop_check: begin
                if (sample) begin
                    next_state = uart_rx_pkg::load_frame;
                end
            end
            default: begin
                next_state = uart_rx_pkg::idle;
            end
        endcase
    end

    assign timer_enable = (state == uart_rx_pkg::start_check) ||
                          (state == uart_rx_pkg::receive) ||
                          (state == uart_rx_pkg::stop_check);
    assign sample_bit   = sync_2;
    assign sample_write = (state == uart_rx_pkg::receive) && sample;

    // payload comes from the sample register, merged at the top
    assign frame.load          = (state == uart_rx_pkg::load_frame);
    assign frame.data          = '0;
    assign frame.framing_error = stop_low;

endmodule

/* uart_receiver/rx_sample_register.sv */
`timescale 1ns/1ns

module rx_sample_register (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     sample_write,
    input  logic                     sample_bit,
    input  uart_rx_pkg::bit_index_t  bit_index,
    input  logic                     clear,
    output uart_rx_pkg::data_t       data
);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            data <= '0;
        end else if (clear) begin
            // upper bits must read zero on short characters
            data <= '0;
        end else if (sample_write) begin
            // index 0 is the start bit, data lands lsb first
            for (int i = 0; i < 8; i++) begin
                if (bit_index == 4'(i + 1)) begin
                    data[i] <= sample_bit;
                end
            end
        end
    end

endmodule

/* rtl/rx_buffer.sv */
`timescale 1ns/1ns

module rx_buffer (
    input  logic                    clk,
    input  logic                    n_rst,
    input  uart_rx_pkg::rx_frame_t  frame,
    input  logic                    data_read,
    output uart_rx_pkg::rx_status_t status
);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            status <= '0;
        end else if (frame.load) begin
            // new character always wins over a read in the same cycle
            status.rx_data       <= frame.data;
            status.data_ready    <= 1'b1;
            // overrun only if the old character was never picked up
            status.overrun_error <= status.data_ready && !data_read;
            status.framing_error <= frame.framing_error;
        end else if (data_read) begin
            // character stays readable, flags go
            status.data_ready    <= 1'b0;
            status.overrun_error <= 1'b0;
            status.framing_error <= 1'b0;
        end
    end

endmodule

/* rtl/apb_uart_rx.sv */
`timescale 1ns/1ns

module apb_uart_rx (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   psel,
    input  uart_rx_pkg::apb_addr_t paddr,
    input  logic                   penable,
    input  logic                   pwrite,
    input  uart_rx_pkg::data_t     pwdata,
    output uart_rx_pkg::data_t     prdata,
    output logic                   pslverr,
    input  logic                   serial_in
);

    uart_rx_pkg::rx_config_t rx_config;
    uart_rx_pkg::rx_status_t rx_status;
    uart_rx_pkg::rx_frame_t  ctrl_frame;
    uart_rx_pkg::rx_frame_t  buffer_frame;
    uart_rx_pkg::bit_index_t bit_index;
    uart_rx_pkg::data_t      sample_data;
    logic                    data_read;
    logic                    timer_enable;
    logic                    sample;
    logic                    sample_bit;
    logic                    sample_write;

    apb_slave apb_slave0 (
        .clk        (clk),
        .n_rst      (n_rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .status     (rx_status),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .data_read  (data_read),
        .config_out (rx_config)
    );

    rx_timer rx_timer0 (
        .clk        (clk),
        .n_rst      (n_rst),
        .enable     (timer_enable),
        .bit_period (rx_config.bit_period),
        .sample     (sample),
        .bit_index  (bit_index)
    );

    rx_control rx_control0 (
        .clk          (clk),
        .n_rst        (n_rst),
        .serial_in    (serial_in),
        .data_size    (rx_config.data_size),
        .sample       (sample),
        .bit_index    (bit_index),
        .timer_enable (timer_enable),
        .sample_bit   (sample_bit),
        .sample_write (sample_write),
        .frame        (ctrl_frame)
    );

    // emptied on each handoff so the next frame starts from zero
    rx_sample_register rx_sample_register0 (
        .clk          (clk),
        .n_rst        (n_rst),
        .sample_write (sample_write),
        .sample_bit   (sample_bit),
        .bit_index    (bit_index),
        .clear        (ctrl_frame.load),
        .data         (sample_data)
    );

    // strobe and stop flag from control, character from the sample register
    assign buffer_frame.load          = ctrl_frame.load;
    assign buffer_frame.data          = sample_data;
    assign buffer_frame.framing_error = ctrl_frame.framing_error;

    rx_buffer rx_buffer0 (
        .clk       (clk),
        .n_rst     (n_rst),
        .frame     (buffer_frame),
        .data_read (data_read),
        .status    (rx_status)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    // free running, low for the first half period
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

/* verification/apb_uart_rx_assertions.sv */
`timescale 1ns/1ns

module apb_uart_rx_assertions (
    input logic                   clk,
    input logic                   n_rst,
    input logic                   psel,
    input logic                   penable,
    input logic                   pwrite,
    input uart_rx_pkg::apb_addr_t paddr,
    input logic                   pslverr,
    input logic                   data_read,
    input logic                   load,
    input logic                   serial_in,
    input uart_rx_pkg::rx_state_t state
);

    logic setup;
    logic read_only;
    logic serial_prev;
    logic line_fell;

    assign setup     = psel && !penable;
    assign read_only = (paddr == uart_rx_pkg::ADDR_STATUS) ||
                       (paddr == uart_rx_pkg::ADDR_ERROR) ||
                       (paddr == uart_rx_pkg::ADDR_RX_DATA);

    // first falling edge on the line since reset
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            serial_prev <= 1'b1;
            line_fell   <= 1'b0;
        end else begin
            serial_prev <= serial_in;
            if (serial_prev && !serial_in) begin
                line_fell <= 1'b1;
            end
        end
    end

    load_single: assert property (@(posedge clk) disable iff (!n_rst) load |=> !load)
        else $error("load strobe held longer than one cycle");

    read_pulse_source: assert property (@(posedge clk) disable iff (!n_rst)
        data_read |-> $past(setup && !pwrite && paddr == uart_rx_pkg::ADDR_RX_DATA))
        else $error("data_read without a data register read");

    slverr_source: assert property (@(posedge clk) disable iff (!n_rst)
        pslverr |-> $past(setup && pwrite && read_only))
        else $error("pslverr without a write to a read only register");

    // nothing may start before the line has ever dropped
    idle_after_reset: assert property (@(posedge clk) disable iff (!n_rst)
        !line_fell |-> state == uart_rx_pkg::idle)
        else $error("receiver left idle before any falling edge");

endmodule

bind apb_uart_rx apb_uart_rx_assertions apb_uart_rx_assertions0 (
    .clk       (clk),
    .n_rst     (n_rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pslverr   (pslverr),
    .data_read (data_read),
    .load      (ctrl_frame.load),
    .serial_in (serial_in),
    .state     (rx_control0.state)
);

/* verification/tb_apb_uart_rx.sv */
`timescale 1ns/1ns

module tb_apb_uart_rx;

    localparam int MAX_ROWS   = 16;
    localparam int ROW_WORDS  = 8;
    localparam int POLL_LIMIT = 100;

    logic                   clk;
    logic                   n_rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    uart_rx_pkg::apb_addr_t paddr;
    uart_rx_pkg::data_t     pwdata;
    uart_rx_pkg::data_t     prdata;
    logic                   pslverr;
    logic                   serial_in;
    integer                 seed;

    // one frame per row, eight hex words per row
    logic [15:0] stim [0:MAX_ROWS*ROW_WORDS-1];

    tb_clock_gen #(.PERIOD(20)) clock_gen0 (.clk(clk));

    apb_uart_rx dut0 (
        .clk       (clk),
        .n_rst     (n_rst),
        .psel      (psel),
        .paddr     (paddr),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .serial_in (serial_in)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input uart_rx_pkg::data_t expected,
                               input uart_rx_pkg::data_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // setup on one falling edge, access on the next, response sampled mid access
    task automatic write_reg(input uart_rx_pkg::apb_addr_t addr, input uart_rx_pkg::data_t value,
                             input logic expect_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = value;
        @(negedge clk);
        check_value($sformatf("pslverr on write to %0d", addr), {7'd0, expect_err},
                    {7'd0, pslverr});
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input uart_rx_pkg::apb_addr_t addr, output uart_rx_pkg::data_t value);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        value = prdata;
        check_value($sformatf("pslverr on read of %0d", addr), 8'h00, {7'd0, pslverr});
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // start bit, data lsb first, stop bit, each period clocks long
    task automatic send_frame(input int period, input int size, input uart_rx_pkg::data_t value,
                              input logic stop);
        int i;
        @(negedge clk);
        serial_in = 1'b0;
        repeat (period) @(negedge clk);
        for (i = 0; i < size; i++) begin
            serial_in = value[i];
            repeat (period) @(negedge clk);
        end
        serial_in = stop;
        repeat (period) @(negedge clk);
        serial_in = 1'b1;
    endtask

    // poll status until the character shows up
    task automatic wait_data_ready(input int row);
        uart_rx_pkg::data_t value;
        int tries;
        tries = 0;
        read_reg(uart_rx_pkg::ADDR_STATUS, value);
        while (value[0] !== 1'b1) begin
            tries++;
            if (tries > POLL_LIMIT) begin
                fail_run($sformatf("timeout waiting for data ready on row %0d", row));
            end
            read_reg(uart_rx_pkg::ADDR_STATUS, value);
        end
    endtask

    task automatic idle_gap();
        int r;
        int gap;
        r   = $random(seed);
        gap = 2 + (r & 31);
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        int row;
        int base;
        uart_rx_pkg::data_t       value;
        uart_rx_pkg::bit_period_t reset_period;
        uart_rx_pkg::data_size_t  reset_size;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        serial_in = 1'b1;
        n_rst     = 1'b0;
        seed      = 32'h60184673;
        $readmemh("verification/uart_rx_stimulus.txt", stim);
        repeat (10) @(negedge clk);
        n_rst = 1'b1;
        @(negedge clk);

        // reset values
        reset_period = uart_rx_pkg::BIT_PERIOD_RESET;
        reset_size   = uart_rx_pkg::DATA_SIZE_RESET;
        read_reg(uart_rx_pkg::ADDR_BIT_PERIOD_LO, value);
        check_value("reset bit period low", reset_period[7:0], value);
        read_reg(uart_rx_pkg::ADDR_BIT_PERIOD_HI, value);
        check_value("reset bit period high", {2'b00, reset_period[13:8]}, value);
        read_reg(uart_rx_pkg::ADDR_DATA_SIZE, value);
        check_value("reset data size", {4'd0, reset_size}, value);
        read_reg(uart_rx_pkg::ADDR_STATUS, value);
        check_value("reset status", 8'h00, value);
        read_reg(uart_rx_pkg::ADDR_ERROR, value);
        check_value("reset error code", 8'h00, value);

        // read back, unused upper bits dropped
        write_reg(uart_rx_pkg::ADDR_BIT_PERIOD_LO, 8'h5a, 1'b0);
        write_reg(uart_rx_pkg::ADDR_BIT_PERIOD_HI, 8'hff, 1'b0);
        write_reg(uart_rx_pkg::ADDR_DATA_SIZE, 8'hf3, 1'b0);
        read_reg(uart_rx_pkg::ADDR_BIT_PERIOD_LO, value);
        check_value("bit period low readback", 8'h5a, value);
        read_reg(uart_rx_pkg::ADDR_BIT_PERIOD_HI, value);
        check_value("bit period high readback", 8'h3f, value);
        read_reg(uart_rx_pkg::ADDR_DATA_SIZE, value);
        check_value("data size readback", 8'h03, value);

        // frames from the data file, period 0 ends the list
        row = 0;
        while (row < MAX_ROWS && stim[row * ROW_WORDS] != 16'h0000) begin
            base = row * ROW_WORDS;
            write_reg(uart_rx_pkg::ADDR_BIT_PERIOD_LO, stim[base][7:0], 1'b0);
            write_reg(uart_rx_pkg::ADDR_BIT_PERIOD_HI, {2'b00, stim[base][13:8]}, 1'b0);
            write_reg(uart_rx_pkg::ADDR_DATA_SIZE, stim[base + 1][7:0], 1'b0);
            idle_gap();
            send_frame(int'(stim[base][13:0]), int'(stim[base + 1][3:0]),
                       stim[base + 2][7:0], stim[base + 3][0]);
            wait_data_ready(row);
            read_reg(uart_rx_pkg::ADDR_STATUS, value);
            check_value($sformatf("row %0d status", row), stim[base + 7][7:0], value);
            read_reg(uart_rx_pkg::ADDR_ERROR, value);
            check_value($sformatf("row %0d error code", row), stim[base + 6][7:0], value);
            // read only registers refuse writes and keep the pending character
            write_reg(uart_rx_pkg::ADDR_STATUS, 8'hff, 1'b1);
            write_reg(uart_rx_pkg::ADDR_ERROR, 8'hff, 1'b1);
            write_reg(uart_rx_pkg::ADDR_RX_DATA, 8'hff, 1'b1);
            read_reg(uart_rx_pkg::ADDR_STATUS, value);
            check_value($sformatf("row %0d status after refused writes", row),
                        stim[base + 7][7:0], value);
            read_reg(uart_rx_pkg::ADDR_ERROR, value);
            check_value($sformatf("row %0d error after refused writes", row),
                        stim[base + 6][7:0], value);
            if (stim[base + 4][0]) begin
                read_reg(uart_rx_pkg::ADDR_RX_DATA, value);
                check_value($sformatf("row %0d data", row), stim[base + 5][7:0], value);
                read_reg(uart_rx_pkg::ADDR_STATUS, value);
                check_value($sformatf("row %0d status after read", row), 8'h00, value);
                read_reg(uart_rx_pkg::ADDR_ERROR, value);
                check_value($sformatf("row %0d error after read", row), 8'h00, value);
            end
            row++;
        end
        if (row == 0) begin
            fail_run("stimulus file holds no frames");
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* verification/uart_rx_stimulus.txt */
// columns in hex: bit_period data_size data stop read_before_next exp_rx_data exp_error exp_ready
// a row with bit_period 0000 ends the list
000a 8 a5 1 1 a5 0 1
0010 7 d3 1 1 53 0 1
0018 6 ff 1 1 3f 0 1
0028 5 a7 1 1 07 0 1
0064 8 3c 1 1 3c 0 1
000c 5 1e 1 1 1e 0 1
// stop bit low, framing error
0014 8 81 0 1 81 1 1
0014 6 2d 1 1 2d 0 1
// two frames without a read between, overrun
0010 8 11 1 0 11 0 1
0010 8 e2 1 1 e2 2 1
// period above one byte
0102 7 55 1 1 55 0 1
000a 8 00 1 1 00 0 1
0000 0 00 0 0 00 0 0

/* build.f */
common/uart_rx_pkg.sv
apb_slave/apb_slave.sv
uart_receiver/rx_timer.sv
uart_receiver/rx_control.sv
uart_receiver/rx_sample_register.sv
rtl/rx_buffer.sv
rtl/apb_uart_rx.sv
verification/tb_clock_gen.sv
verification/apb_uart_rx_assertions.sv
verification/tb_apb_uart_rx.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_apb_uart_rx
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
